/* bench/exec_testdata.txt */
# kind func(dec) muxa muxb fwd_a fwd_rt pause hold | pc rs rt ext fw_alu fw_mem (hex)
# expected (hex): A,P result store spc | M,B,H hi lo spc(unchecked)
A 3  0 0 0 0 0 0 0 7fffffff 00000001 0 aaaa0000 0000bbbb 80000000 00000001 0
A 4  0 0 0 0 0 0 0 00000005 00000007 0 aaaa0000 0000bbbb fffffffe 00000007 0
A 5  0 0 0 0 0 0 0 00000000 00000001 0 aaaa0000 0000bbbb ffffffff 00000001 0
A 6  0 0 0 0 0 0 0 f0f00000 0000ff00 0 aaaa0000 0000bbbb f0f0ff00 0000ff00 0
A 7  0 0 0 0 0 0 0 ff00ff00 0ff00ff0 0 aaaa0000 0000bbbb 0f000f00 0ff00ff0 0
A 8  0 0 0 0 0 0 0 ffff0000 ff00ff00 0 aaaa0000 0000bbbb 00ffff00 ff00ff00 0
A 9  0 0 0 0 0 0 0 f0f0f0f0 0f0f0000 0 aaaa0000 0000bbbb 00000f0f 0f0f0000 0
A 10 0 0 0 0 0 0 0 ffffffff 00000001 0 aaaa0000 0000bbbb 00000001 00000001 0
A 11 0 0 0 0 0 0 0 ffffffff 00000001 0 aaaa0000 0000bbbb 00000000 00000001 0
A 10 0 0 0 0 0 0 0 00000001 80000000 0 aaaa0000 0000bbbb 00000000 80000000 0
A 11 0 0 0 0 0 0 0 00000001 80000000 0 aaaa0000 0000bbbb 00000001 80000000 0
A 12 0 0 0 0 0 0 0 00000004 8000000f 0 aaaa0000 0000bbbb 000000f0 8000000f 0
A 13 0 0 0 0 0 0 0 00000008 80000000 0 aaaa0000 0000bbbb 00800000 80000000 0
A 14 0 0 0 0 0 0 0 00000008 80000000 0 aaaa0000 0000bbbb ff800000 80000000 0
A 14 0 0 0 0 0 0 0 0000003f f0000000 0 aaaa0000 0000bbbb ffffffff f0000000 0
A 12 0 1 0 0 0 0 0 00000010 11111111 0000abcd aaaa0000 0000bbbb abcd0000 11111111 0
A 1  2 0 0 0 0 0 0 00000001 00000002 deadbeef aaaa0000 0000bbbb deadbeef 00000002 0
A 1  0 0 1 0 0 0 0 00000001 00000002 0 aaaa0000 0000bbbb aaaa0000 00000002 0
A 1  0 0 2 0 0 0 0 00000001 00000002 0 aaaa0000 0000bbbb 0000bbbb 00000002 0
A 2  0 0 0 1 0 0 0 00000001 00000002 0 aaaa0000 0000bbbb aaaa0000 aaaa0000 0
A 2  0 0 0 2 0 0 0 00000001 00000002 0 aaaa0000 0000bbbb 0000bbbb 0000bbbb 0
A 3  0 0 1 2 0 0 0 00000001 00000002 0 aaaa0000 0000bbbb aaaabbbb 0000bbbb 0
A 1  1 0 0 0 0 0 0 00000001 00000002 0 aaaa0000 0000bbbb 00000004 00000002 0
P 1  1 0 0 0 0 0 100 0 0 0 aaaa0000 0000bbbb 00000104 00000000 100
P 1  1 0 0 0 0 1 200 0 0 0 aaaa0000 0000bbbb 00000204 00000000 100
P 1  1 0 0 0 1 0 300 0 0 0 aaaa0000 0000bbbb 00000204 00000000 100
P 1  1 0 0 0 0 0 300 0 0 0 aaaa0000 0000bbbb 00000304 00000000 300
A 1  3 0 0 0 0 0 300 0 0 0 aaaa0000 0000bbbb 00000300 00000000 300
A 3  1 1 0 0 0 0 300 0 0 10 aaaa0000 0000bbbb 00000314 00000000 300
H 21 0 0 0 0 0 0 300 01234567 89abcdef 0 aaaa0000 0000bbbb 01234567 89abcdef 300
M 15 0 0 0 0 0 0 300 00000007 fffffffd 0 aaaa0000 0000bbbb ffffffff ffffffeb 300
M 16 0 0 0 0 0 0 300 ffffffff ffffffff 0 aaaa0000 0000bbbb fffffffe 00000001 300
M 15 0 0 0 0 0 0 300 80000000 80000000 0 aaaa0000 0000bbbb 40000000 00000000 300
M 17 0 0 0 0 0 0 300 fffffff9 00000002 0 aaaa0000 0000bbbb ffffffff fffffffd 300
M 17 0 0 0 0 0 0 300 00000007 fffffffe 0 aaaa0000 0000bbbb 00000001 fffffffd 300
M 18 0 0 0 0 0 0 300 ffffffff 00000010 0 aaaa0000 0000bbbb 0000000f 0fffffff 300
M 17 0 0 0 0 0 0 300 80000000 ffffffff 0 aaaa0000 0000bbbb 00000000 80000000 300
M 17 0 0 0 0 0 0 300 ffffff9c fffffff9 0 aaaa0000 0000bbbb fffffffe 0000000e 300
B 15 0 0 0 0 0 0 300 00000007 fffffffd deadbeef aaaa0000 0000bbbb ffffffff ffffffeb 300
H 21 0 0 0 0 0 0 300 cafef00d 0badc0de 0 aaaa0000 0000bbbb cafef00d 0badc0de 300

/* verilog.f */
design/exec_pkg.sv
design/exec_operands.sv
design/pc_capture.sv
design/barrel_shifter.sv
design/alu_core.sv
design/hilo_muldiv.sv
design/result_select.sv
design/exec_stage.sv
bench/exec_stage_checker.sv
bench/exec_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the execute stage and its testbench with Verilator, then run it.
# The exit status of the simulation is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module exec_stage_tb -o exec_stage_sim

./obj_dir/exec_stage_sim

/* bench/exec_stage_tb.sv */
//--------------------------------------------------------------------------
// Testbench for the execute stage. Reads one vector per line from the
// test data file, drives the DUT and compares results, store data, the
// pc registers and the multiply/divide results with the file's values.
// Vector kinds are A for combinational checks, P for the pc registers,
// M for mul/div, B for mul/div with ignored requests while busy and
// H for an MTHI/MTLO write and read back.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module exec_stage_tb import exec_pkg::*; ();

    localparam int    CLK_PERIOD        = 40;
    localparam int    DRIVE_DELAY       = 2;
    localparam int    CYCLES_PER_VECTOR = 40;
    localparam int    WATCHDOG_SLACK    = 100;
    localparam int    FIELDS            = 17;
    localparam string DATA_FILE         = "bench/exec_testdata.txt";

    logic      clk;
    logic      rst;
    logic      pause;
    logic      spc_hold;
    alu_func_e alu_func;
    muxa_sel_e muxa_sel;
    muxb_sel_e muxb_sel;
    fwd_sel_e  muxa_fwd;
    fwd_sel_e  rt_fwd;
    word_t     pc;
    word_t     rs;
    word_t     rt;
    word_t     ext;
    word_t     fw_alu;
    word_t     fw_mem;
    word_t     alu_res;
    word_t     store_data;
    word_t     spc;
    logic      md_busy;

    // fields of the current vector
    string v_kind;
    int    v_func, v_ma, v_mb, v_fa, v_fb, v_pz, v_hd;
    word_t v_pc, v_rs, v_rt, v_ext, v_fwa, v_fwm, v_exp1, v_exp2, v_spc;
    string test_name;
    int    n_vectors = 0;
    logic  vectors_counted = 1'b0;

    exec_stage UUT
    (
        .clk          (clk),
        .rst          (rst),
        .pause_i      (pause),
        .spc_hold_i   (spc_hold),
        .alu_func_i   (alu_func),
        .muxa_sel_i   (muxa_sel),
        .muxb_sel_i   (muxb_sel),
        .muxa_fwd_i   (muxa_fwd),
        .rt_fwd_i     (rt_fwd),
        .pc_i         (pc),
        .rs_i         (rs),
        .rt_i         (rt),
        .ext_i        (ext),
        .fw_alu_i     (fw_alu),
        .fw_mem_i     (fw_mem),
        .alu_res_o    (alu_res),
        .store_data_o (store_data),
        .spc_o        (spc),
        .md_busy_o    (md_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("ERR %s %s: expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_busy(input logic exp);
        if (md_busy !== exp)
            abort_run($sformatf("ERR %s busy: expected %b actual %b", test_name, exp, md_busy));
    endtask

    task automatic wait_drive_slot;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic parse_line(input string line, output int n);
        if (line.len() == 0 || line[0] == "#")
            n = 0;                                  // comment line
        else
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %h %h %h %h %h %h %h %h %h",
                        v_kind, v_func, v_ma, v_mb, v_fa, v_fb, v_pz, v_hd, v_pc,
                        v_rs, v_rt, v_ext, v_fwa, v_fwm, v_exp1, v_exp2, v_spc);
    endtask

    task automatic apply_vector;
        alu_func = alu_func_e'(v_func[4:0]);
        muxa_sel = muxa_sel_e'(v_ma[1:0]);
        muxb_sel = muxb_sel_e'(v_mb[1:0]);
        muxa_fwd = fwd_sel_e'(v_fa[2:0]);
        rt_fwd   = fwd_sel_e'(v_fb[2:0]);
        pause    = v_pz[0];
        spc_hold = v_hd[0];
        pc       = v_pc;
        rs       = v_rs;
        rt       = v_rt;
        ext      = v_ext;
        fw_alu   = v_fwa;
        fw_mem   = v_fwm;
    endtask

    task automatic check_stage_outputs;
        check_word("result", v_exp1, alu_res);
        check_word("store data", v_exp2, store_data);
        check_word("spc", v_spc, spc);
    endtask

    task automatic read_hilo;
        wait_drive_slot;
        alu_func = ALU_MFHI;
        @(negedge clk);
        check_word("hi", v_exp1, alu_res);
        wait_drive_slot;
        alu_func = ALU_MFLO;
        @(negedge clk);
        check_word("lo", v_exp2, alu_res);
    endtask

    task automatic run_muldiv(input logic interfere);
        @(negedge clk);
        check_busy(1'b0);                           // start must see idle
        wait_drive_slot;
        alu_func = ALU_NOP;
        @(negedge clk);
        check_busy(1'b1);
        if (interfere)
        begin
            wait_drive_slot;
            alu_func = ALU_MTHI;                    // dropped while busy
            rs       = v_ext;
            wait_drive_slot;
            alu_func = ALU_DIVU;                    // second start is dropped
            wait_drive_slot;
            alu_func = ALU_MTLO;
            wait_drive_slot;
            alu_func = ALU_NOP;
        end
        while (md_busy)
            @(negedge clk);
        read_hilo();
    endtask

    task automatic run_hilo_write;
        wait_drive_slot;
        alu_func = ALU_MTLO;                        // MTHI done at this edge
        rs       = v_rt;
        read_hilo();
    endtask

    // watchdog sized from the number of vectors
    initial
    begin
        wait (vectors_counted);
        #(CLK_PERIOD * (CYCLES_PER_VECTOR * n_vectors + WATCHDOG_SLACK));
        abort_run("timeout: the run hung waiting on the DUT");
    end

    initial
    begin
        int    fd;
        int    n;
        int    line_no;
        string line;

        rst      = 1'b0;
        pause    = 1'b0;
        spc_hold = 1'b0;
        alu_func = ALU_NOP;
        muxa_sel = MUXA_RS;
        muxb_sel = MUXB_RT;
        muxa_fwd = FW_NONE;
        rt_fwd   = FW_NONE;
        pc       = '0;
        rs       = '0;
        rt       = '0;
        ext      = '0;
        fw_alu   = '0;
        fw_mem   = '0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
            abort_run("cannot open the test data file");
        while ($fgets(line, fd) != 0)
        begin
            parse_line(line, n);
            if (n == FIELDS)
                n_vectors++;
            else if (n > 0)
                abort_run($sformatf("malformed test data line: %s", line));
        end
        $fclose(fd);
        if (n_vectors == 0)
            abort_run("the test data file holds no vectors");
        vectors_counted = 1'b1;

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;

        fd      = $fopen(DATA_FILE, "r");
        line_no = 0;
        while ($fgets(line, fd) != 0)
        begin
            line_no++;
            parse_line(line, n);
            if (n == FIELDS)
            begin
                test_name = $sformatf("line %0d kind %s", line_no, v_kind);
                wait_drive_slot;
                apply_vector();
                if (v_kind == "A")
                begin
                    @(negedge clk);
                    check_stage_outputs();
                end
                else if (v_kind == "P")
                begin
                    @(posedge clk);                 // registers capture here
                    @(negedge clk);
                    check_stage_outputs();
                end
                else if (v_kind == "M")
                    run_muldiv(1'b0);
                else if (v_kind == "B")
                    run_muldiv(1'b1);
                else if (v_kind == "H")
                    run_hilo_write();
                else
                    abort_run($sformatf("unknown vector kind on line %0d", line_no));
            end
        end
        $fclose(fd);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* bench/exec_stage_checker.sv */
//--------------------------------------------------------------------------
// Concurrent assertions on the multiply/divide unit, bound into every
// hilo_muldiv instance. Watches reset, the start of an operation, the
// length of the busy window and the hi/lo registers while busy.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module exec_stage_checker import exec_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input alu_func_e func_i,
    input md_state_e state_i,
    input logic      busy_i,
    input word_t     hi_i,
    input word_t     lo_i
);

    int unsigned busy_len;      // consecutive busy cycles so far
    logic        start_idle;

    assign start_idle = (state_i == MD_IDLE)
                        && (func_i inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU});

    always_ff @(posedge clk)
    begin
        if (!rst || !busy_i)
            busy_len <= 0;
        else
            busy_len <= busy_len + 1;
    end

    a_idle_after_reset: assert property (@(posedge clk) $rose(rst) |-> !busy_i)
        else $error("md unit busy in the first cycle after reset");

    a_start_raises_busy: assert property (@(posedge clk) disable iff (!rst)
        start_idle |=> busy_i)
        else $error("md start while idle did not raise busy");

    a_busy_length: assert property (@(posedge clk) disable iff (!rst)
        $fell(busy_i) |-> (busy_len == MD_STEPS + 1))
        else $error("md busy window is not MD_STEPS plus 1 cycles long");

    // hi and lo only move in the fix cycle or while idle
    a_hilo_stable: assert property (@(posedge clk) disable iff (!rst)
        (busy_i && $past(busy_i)) |-> ($stable(hi_i) && $stable(lo_i)))
        else $error("hi or lo changed while the md unit was busy");

endmodule

bind hilo_muldiv exec_stage_checker u_checker
(
    .clk     (clk),
    .rst     (rst),
    .func_i  (func_i),
    .state_i (state),
    .busy_i  (busy_o),
    .hi_i    (hi_o),
    .lo_i    (lo_o)
);

/* design/exec_stage.sv */
//--------------------------------------------------------------------------
// Execute stage top level. Connects operand selection and the pc
// registers to the ALU and the multiply/divide unit, and picks the stage
// result. md_busy_o goes to the pipeline controller for stalling.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module exec_stage import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      pause_i,
    input  logic      spc_hold_i,
    input  alu_func_e alu_func_i,
    input  muxa_sel_e muxa_sel_i,
    input  muxb_sel_e muxb_sel_i,
    input  fwd_sel_e  muxa_fwd_i,
    input  fwd_sel_e  rt_fwd_i,
    input  word_t     pc_i,
    input  word_t     rs_i,
    input  word_t     rt_i,
    input  word_t     ext_i,
    input  word_t     fw_alu_i,
    input  word_t     fw_mem_i,
    output word_t     alu_res_o,
    output word_t     store_data_o,
    output word_t     spc_o,
    output logic      md_busy_o
);

    word_t op_a;
    word_t op_b;
    word_t next_pc;
    word_t alu_result;
    word_t hi;
    word_t lo;

    exec_operands u_operands
    (
        .muxa_sel_i   (muxa_sel_i),
        .muxb_sel_i   (muxb_sel_i),
        .muxa_fwd_i   (muxa_fwd_i),
        .rt_fwd_i     (rt_fwd_i),
        .rs_i         (rs_i),
        .rt_i         (rt_i),
        .ext_i        (ext_i),
        .fw_alu_i     (fw_alu_i),
        .fw_mem_i     (fw_mem_i),
        .next_pc_i    (next_pc),
        .spc_i        (spc_o),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .store_data_o (store_data_o)
    );

    pc_capture u_pc
    (
        .clk        (clk),
        .rst        (rst),
        .pause_i    (pause_i),
        .spc_hold_i (spc_hold_i),
        .pc_i       (pc_i),
        .next_pc_o  (next_pc),
        .spc_o      (spc_o)
    );

    alu_core u_alu
    (
        .func_i   (alu_func_i),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    hilo_muldiv u_muldiv
    (
        .clk    (clk),
        .rst    (rst),
        .func_i (alu_func_i),
        .a_i    (op_a),
        .b_i    (op_b),
        .hi_o   (hi),
        .lo_o   (lo),
        .busy_o (md_busy_o)
    );

    result_select u_result
    (
        .func_i   (alu_func_i),
        .alu_i    (alu_result),
        .hi_i     (hi),
        .lo_i     (lo),
        .result_o (alu_res_o)
    );

endmodule

/* design/result_select.sv */
//--------------------------------------------------------------------------
// Stage result mux. MFHI and MFLO take hi and lo, every other code
// takes the ALU result.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module result_select import exec_pkg::*;
(
    input  alu_func_e func_i,
    input  word_t     alu_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    output word_t     result_o
);

    always_comb
    begin
        case (func_i)
            ALU_MFHI: result_o = hi_i;
            ALU_MFLO: result_o = lo_i;
            default:  result_o = alu_i;    // alu gives zero for mul/div ops
        endcase
    end

endmodule

/* design/hilo_muldiv.sv */
//--------------------------------------------------------------------------
// Sequential multiply/divide unit with the hi and lo registers.
// A start while idle runs MD_STEPS iteration cycles on magnitudes, then
// one cycle fixes the signs and loads hi and lo. busy_o is high for all
// of those cycles; starts and MTHI/MTLO seen while busy are dropped.
// MFHI and MFLO read hi_o and lo_o directly.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module hilo_muldiv import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  alu_func_e func_i,
    input  word_t     a_i,
    input  word_t     b_i,
    output word_t     hi_o,
    output word_t     lo_o,
    output logic      busy_o
);

    typedef logic [$clog2(MD_STEPS)-1:0] cnt_t;

    md_state_e           state;
    cnt_t                cnt;
    logic                start_ok;
    logic                is_mul;
    logic                is_signed;
    logic                a_neg;
    logic                b_neg;
    logic                op_mul;       // running op is a multiply
    logic                neg_q;        // product or quotient negative
    logic                neg_r;        // remainder negative
    word_t               opnd;         // multiplicand or divisor magnitude
    logic [2*DATA_W-1:0] work;         // {acc/rem, multiplier/quotient}
    logic [2*DATA_W-1:0] work_step;
    logic [2*DATA_W-1:0] prod_fix;
    logic [DATA_W:0]     add_sum;
    logic [DATA_W:0]     rem_sh;
    logic [DATA_W:0]     diff;
    word_t               hi_fix;
    word_t               lo_fix;

    function automatic word_t mag(word_t v, logic neg);
        return neg ? (~v + 1'b1) : v;
    endfunction

    assign is_mul    = (func_i == ALU_MULT) || (func_i == ALU_MULTU);
    assign is_signed = (func_i == ALU_MULT) || (func_i == ALU_DIV);
    assign start_ok  = (state == MD_IDLE) && (is_mul || func_i == ALU_DIV
                                              || func_i == ALU_DIVU);
    assign a_neg     = is_signed && a_i[DATA_W-1];
    assign b_neg     = is_signed && b_i[DATA_W-1];
    assign busy_o    = (state != MD_IDLE);

    // one iteration of shift-and-add or restoring subtract
    always_comb
    begin
        add_sum = {1'b0, work[2*DATA_W-1:DATA_W]} + (work[0] ? {1'b0, opnd} : '0);
        rem_sh  = work[2*DATA_W-1:DATA_W-1];            // rem shifted with next bit in
        diff    = rem_sh - {1'b0, opnd};
        if (op_mul)
            work_step = {add_sum, work[DATA_W-1:1]};
        else if (!diff[DATA_W])
            work_step = {diff[DATA_W-1:0], work[DATA_W-2:0], 1'b1};
        else
            work_step = {rem_sh[DATA_W-1:0], work[DATA_W-2:0], 1'b0};
    end

    // sign fix for the final cycle
    always_comb
    begin
        prod_fix = neg_q ? -work : work;
        if (op_mul)
        begin
            hi_fix = prod_fix[2*DATA_W-1:DATA_W];
            lo_fix = prod_fix[DATA_W-1:0];
        end
        else
        begin
            lo_fix = neg_q ? -work[DATA_W-1:0] : work[DATA_W-1:0];
            hi_fix = neg_r ? -work[2*DATA_W-1:DATA_W] : work[2*DATA_W-1:DATA_W];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= MD_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                MD_IDLE:
                begin
                    if (start_ok)
                    begin
                        state <= MD_RUN;
                        cnt   <= cnt_t'(MD_STEPS - 1);
                    end
                end
                MD_RUN:
                begin
                    if (cnt == '0)
                        state <= MD_FIX;
                    cnt <= cnt - 1'b1;
                end
                MD_FIX:  state <= MD_IDLE;
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            opnd   <= mag(b_i, b_neg);
            work   <= {{DATA_W{1'b0}}, mag(a_i, a_neg)};
            op_mul <= is_mul;
            neg_q  <= a_neg ^ b_neg;
            neg_r  <= a_neg;                   // remainder follows dividend
        end
        else if (state == MD_RUN)
        begin
            work <= work_step;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == MD_FIX)
        begin
            hi_o <= hi_fix;
            lo_o <= lo_fix;
        end
        else if (state == MD_IDLE)
        begin
            if (func_i == ALU_MTHI)
                hi_o <= a_i;
            if (func_i == ALU_MTLO)
                lo_o <= a_i;
        end
    end

endmodule

/* design/alu_core.sv */
//--------------------------------------------------------------------------
// Integer ALU. Add, subtract, logic, signed and unsigned compare and
// pass-through of either operand. Shifts come from the barrel shifter,
// which shifts b_i by a_i bits 4..0. Unknown codes give zero.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module alu_core import exec_pkg::*;
(
    input  alu_func_e func_i,
    input  word_t     a_i,
    input  word_t     b_i,
    output word_t     result_o
);

    word_t shift_res;

    barrel_shifter u_shifter
    (
        .func_i    (func_i),
        .value_i   (b_i),
        .amount_i  (a_i[SHAMT_W-1:0]),
        .shifted_o (shift_res)
    );

    always_comb
    begin
        case (func_i)
            ALU_PA:   result_o = a_i;
            ALU_PB:   result_o = b_i;
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB,
            ALU_SUBU: result_o = a_i - b_i;        // no overflow trap here
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_NOR:  result_o = ~(a_i | b_i);
            ALU_SLT:  result_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = word_t'(a_i < b_i);
            ALU_SLL,
            ALU_SRL,
            ALU_SRA:  result_o = shift_res;
            default:  result_o = '0;               // mul/div and nop
        endcase
    end

endmodule

/* design/barrel_shifter.sv */
//--------------------------------------------------------------------------
// Logarithmic barrel shifter for SLL, SRL and SRA. Left shifts reuse the
// right-shift stages on a bit-reversed word. Non-shift codes give zero.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module barrel_shifter import exec_pkg::*;
(
    input  alu_func_e func_i,
    input  word_t     value_i,
    input  shamt_t    amount_i,
    output word_t     shifted_o
);

    logic  left;
    logic  fill;
    word_t stage;

    function automatic word_t bit_rev(word_t v);
        word_t r;
        for (int i = 0; i < DATA_W; i++)
        begin
            r[i] = v[DATA_W-1-i];
        end
        return r;
    endfunction

    always_comb
    begin
        left  = (func_i == ALU_SLL);
        fill  = (func_i == ALU_SRA) && value_i[DATA_W-1];   // sign fill for sra
        stage = left ? bit_rev(value_i) : value_i;
        for (int s = 0; s < SHAMT_W; s++)
        begin
            if (amount_i[s])
                stage = word_t'($signed({fill, stage}) >>> (1 << s));
        end

        case (func_i)
            ALU_SLL:       shifted_o = bit_rev(stage);
            ALU_SRL,
            ALU_SRA:       shifted_o = stage;
            default:       shifted_o = '0;
        endcase
    end

endmodule

/* design/pc_capture.sv */
//--------------------------------------------------------------------------
// Next-PC and saved-PC registers of the execute stage. next_pc keeps
// pc plus 4 for link instructions, spc keeps the pc for exception return.
// Both freeze on pause; spc also freezes on its own hold strobe.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module pc_capture import exec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pause_i,
    input  logic  spc_hold_i,
    input  word_t pc_i,
    output word_t next_pc_o,
    output word_t spc_o
);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            next_pc_o <= '0;
        end
        else if (!pause_i)
        begin
            next_pc_o <= pc_i + word_t'(4);    // return address
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            spc_o <= '0;
        end
        else if (!(pause_i || spc_hold_i))
        begin
            spc_o <= pc_i;
        end
    end

endmodule

/* design/exec_operands.sv */
//--------------------------------------------------------------------------
// Operand selection for the execute stage. Applies forwarding from the
// ALU and memory stages to rs and rt, then picks the A and B operands.
// The forwarded rt also leaves as store data for the memory stage.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module exec_operands import exec_pkg::*;
(
    input  muxa_sel_e muxa_sel_i,
    input  muxb_sel_e muxb_sel_i,
    input  fwd_sel_e  muxa_fwd_i,
    input  fwd_sel_e  rt_fwd_i,
    input  word_t     rs_i,
    input  word_t     rt_i,
    input  word_t     ext_i,
    input  word_t     fw_alu_i,
    input  word_t     fw_mem_i,
    input  word_t     next_pc_i,
    input  word_t     spc_i,
    output word_t     op_a_o,
    output word_t     op_b_o,
    output word_t     store_data_o
);

    word_t rs_fwd;
    word_t rt_fwd;

    always_comb
    begin
        case (muxa_fwd_i)
            FW_ALU:  rs_fwd = fw_alu_i;        // result still in ex/mem
            FW_MEM:  rs_fwd = fw_mem_i;        // load or older result
            default: rs_fwd = rs_i;
        endcase

        case (rt_fwd_i)
            FW_ALU:  rt_fwd = fw_alu_i;
            FW_MEM:  rt_fwd = fw_mem_i;
            default: rt_fwd = rt_i;
        endcase
    end

    always_comb
    begin
        case (muxa_sel_i)
            MUXA_PC:  op_a_o = next_pc_i;      // link address
            MUXA_EXT: op_a_o = ext_i;
            MUXA_SPC: op_a_o = spc_i;          // exception return pc
            default:  op_a_o = rs_fwd;
        endcase

        case (muxb_sel_i)
            MUXB_EXT: op_b_o = ext_i;
            default:  op_b_o = rt_fwd;
        endcase
    end

    assign store_data_o = rt_fwd;

endmodule

/* design/exec_pkg.sv */
//--------------------------------------------------------------------------
// Shared widths, data types and operation codes of the execute stage.
// Every execute-stage module imports this package in its header.
//--------------------------------------------------------------------------

package exec_pkg;

    localparam int DATA_W   = 32;           // datapath width
    localparam int SHAMT_W  = 5;            // shift amount width
    localparam int MD_STEPS = 32;           // mul/div iteration cycles

    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // operation code from decode
    typedef enum logic [4:0] {
        ALU_NOP   = 5'd0,
        ALU_PA    = 5'd1,
        ALU_PB    = 5'd2,
        ALU_ADD   = 5'd3,
        ALU_SUB   = 5'd4,
        ALU_SUBU  = 5'd5,
        ALU_OR    = 5'd6,
        ALU_AND   = 5'd7,
        ALU_XOR   = 5'd8,
        ALU_NOR   = 5'd9,
        ALU_SLT   = 5'd10,
        ALU_SLTU  = 5'd11,
        ALU_SLL   = 5'd12,
        ALU_SRL   = 5'd13,
        ALU_SRA   = 5'd14,
        ALU_MULT  = 5'd15,
        ALU_MULTU = 5'd16,
        ALU_DIV   = 5'd17,
        ALU_DIVU  = 5'd18,
        ALU_MFHI  = 5'd19,
        ALU_MFLO  = 5'd20,
        ALU_MTHI  = 5'd21,
        ALU_MTLO  = 5'd22
    } alu_func_e;

    typedef enum logic [1:0] {MUXA_RS = 2'd0, MUXA_PC = 2'd1, MUXA_EXT = 2'd2, MUXA_SPC = 2'd3}
        muxa_sel_e;

    typedef enum logic [1:0] {MUXB_RT = 2'd0, MUXB_EXT = 2'd1} muxb_sel_e;

    typedef enum logic [2:0] {FW_NONE = 3'd0, FW_ALU = 3'd1, FW_MEM = 3'd2} fwd_sel_e;

    typedef enum logic [1:0] {MD_IDLE = 2'd0, MD_RUN = 2'd1, MD_FIX = 2'd2} md_state_e;

endpackage
